//--- Makefile
# Verilator simulation of the mips_lite core.

VERILATOR ?= verilator
TOP       ?= tb_mips_lite
FLAGS     ?= --assert
FILELIST  ?= mips_lite_top.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# Build, run, and pass only if the pass line shows up in the output.
sim:
	$(VERILATOR) --binary --timing --timescale 1ns/1ps $(FLAGS) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

//--- hw/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                 clk,
    input  logic                 rst_n,

    // Instruction queue side.
    input  logic                 queue_empty_i,
    input  mips_lite_pkg::word_t queue_data_i,
    output logic                 pop_o,

    // Data bus, Wishbone classic master.
    output logic                 dbus_cyc_o,
    output logic                 dbus_stb_o,
    output logic                 dbus_we_o,
    output mips_lite_pkg::addr_t dbus_adr_o,
    output mips_lite_pkg::word_t dbus_dat_o,
    input  mips_lite_pkg::word_t dbus_dat_i,
    input  logic                 dbus_ack_i
);

    mips_lite_pkg::exec_state_t state;
    mips_lite_pkg::word_t       inst_q;
    mips_lite_pkg::word_t       rf [32];

    mips_lite_pkg::opcode_t  opcode;
    mips_lite_pkg::opcode_t  funct;
    mips_lite_pkg::reg_idx_t rs;
    mips_lite_pkg::reg_idx_t rt;
    mips_lite_pkg::reg_idx_t rd;
    logic [15:0]             imm;

    mips_lite_pkg::word_t    rs_val;
    mips_lite_pkg::word_t    rt_val;
    mips_lite_pkg::word_t    simm;
    mips_lite_pkg::word_t    alu_res;
    mips_lite_pkg::reg_idx_t alu_dst;
    logic                    alu_we;
    logic                    is_lw;
    logic                    is_sw;
    logic                    is_mem;

    logic                    rf_we;
    mips_lite_pkg::reg_idx_t rf_waddr;
    mips_lite_pkg::word_t    rf_wdata;

    // ========================================================================
    // Decode
    // ========================================================================

    assign opcode = inst_q[31:26];
    assign rs     = inst_q[25:21];
    assign rt     = inst_q[20:16];
    assign rd     = inst_q[15:11];
    assign imm    = inst_q[15:0];
    assign funct  = inst_q[5:0];

    assign simm   = {{16{imm[15]}}, imm};
    assign rs_val = (rs == '0) ? '0 : rf[rs];
    assign rt_val = (rt == '0) ? '0 : rf[rt];

    assign is_lw  = (opcode == mips_lite_pkg::OP_LW);
    assign is_sw  = (opcode == mips_lite_pkg::OP_SW);
    assign is_mem = is_lw || is_sw;

    // Unknown opcodes and function codes leave alu_we low.
    always_comb begin
        alu_res = '0;
        alu_dst = rt;
        alu_we  = 1'b0;
        case (opcode)
            mips_lite_pkg::OP_SPECIAL: begin
                alu_dst = rd;
                alu_we  = 1'b1;
                case (funct)
                    mips_lite_pkg::FN_ADDU: alu_res = rs_val + rt_val;
                    mips_lite_pkg::FN_SUBU: alu_res = rs_val - rt_val;
                    mips_lite_pkg::FN_AND:  alu_res = rs_val & rt_val;
                    mips_lite_pkg::FN_OR:   alu_res = rs_val | rt_val;
                    mips_lite_pkg::FN_XOR:  alu_res = rs_val ^ rt_val;
                    default:                alu_we  = 1'b0;
                endcase
            end
            mips_lite_pkg::OP_ADDIU: begin
                alu_res = rs_val + simm;
                alu_we  = 1'b1;
            end
            mips_lite_pkg::OP_ORI: begin
                alu_res = rs_val | {16'h0000, imm};
                alu_we  = 1'b1;
            end
            mips_lite_pkg::OP_LUI: begin
                alu_res = {imm, 16'h0000};
                alu_we  = 1'b1;
            end
            default: alu_we = 1'b0;
        endcase
    end

    // ========================================================================
    // Register file
    // ========================================================================

    assign rf_we    = ((state == mips_lite_pkg::EX_RUN) && alu_we) ||
                      ((state == mips_lite_pkg::EX_MEM) && is_lw && dbus_ack_i);
    assign rf_waddr = (state == mips_lite_pkg::EX_MEM) ? rt : alu_dst;
    assign rf_wdata = (state == mips_lite_pkg::EX_MEM) ? dbus_dat_i : alu_res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we && (rf_waddr != '0)) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

    // ========================================================================
    // Control FSM and data bus
    // ========================================================================

    // Pop from idle, or back to back after a non-memory instruction.
    assign pop_o = !queue_empty_i &&
                   ((state == mips_lite_pkg::EX_IDLE) ||
                    ((state == mips_lite_pkg::EX_RUN) && !is_mem));

    always_ff @(posedge clk) begin
        if (pop_o) begin
            inst_q <= queue_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mips_lite_pkg::EX_IDLE;
        end else begin
            case (state)
                mips_lite_pkg::EX_IDLE: begin
                    if (pop_o) state <= mips_lite_pkg::EX_RUN;
                end
                mips_lite_pkg::EX_RUN: begin
                    if (is_mem)      state <= mips_lite_pkg::EX_MEM;
                    else if (!pop_o) state <= mips_lite_pkg::EX_IDLE;
                end
                mips_lite_pkg::EX_MEM: begin
                    if (dbus_ack_i) state <= mips_lite_pkg::EX_IDLE;
                end
                default: state <= mips_lite_pkg::EX_IDLE;
            endcase
        end
    end

    // Operands cannot change in EX_MEM, so the bus fields stay stable.
    assign dbus_cyc_o = (state == mips_lite_pkg::EX_MEM);
    assign dbus_stb_o = dbus_cyc_o;
    assign dbus_we_o  = dbus_cyc_o && is_sw;
    assign dbus_adr_o = rs_val + simm;
    assign dbus_dat_o = rt_val;

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter mips_lite_pkg::addr_t RESET_PC = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // Instruction queue side.
    input  logic                 queue_full_i,
    output logic                 push_o,
    output mips_lite_pkg::word_t push_data_o,

    // Instruction bus, Wishbone classic read-only master.
    output logic                 ibus_cyc_o,
    output logic                 ibus_stb_o,
    output mips_lite_pkg::addr_t ibus_adr_o,
    input  mips_lite_pkg::word_t ibus_dat_i,
    input  logic                 ibus_ack_i
);

    mips_lite_pkg::addr_t pc;
    logic                 busy;

    // One read in flight at most. A new read starts only with room in the
    // queue, so the returning word can always be pushed.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            pc   <= RESET_PC;
        end else if (busy) begin
            if (ibus_ack_i) begin
                busy <= 1'b0;
                pc   <= pc + mips_lite_pkg::addr_t'(4);
            end
        end else if (!queue_full_i) begin
            busy <= 1'b1;
        end
    end

    assign ibus_cyc_o = busy;
    assign ibus_stb_o = busy;
    assign ibus_adr_o = pc;

    // Push in the ack cycle.
    assign push_o      = busy && ibus_ack_i;
    assign push_data_o = ibus_dat_i;

endmodule

//--- hw/inst_queue.sv
`timescale 1ns/1ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 push_i,
    input  mips_lite_pkg::word_t push_data_i,

    input  logic                 pop_i,
    output mips_lite_pkg::word_t pop_data_o,

    output logic                 full_o,
    output logic                 empty_o
);

    localparam int AW = $clog2(QUEUE_DEPTH);

    typedef logic [AW-1:0] ptr_t;
    typedef logic [AW:0]   cnt_t;

    mips_lite_pkg::word_t mem [QUEUE_DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;

    logic do_push;
    logic do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // Pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
            if (do_push && !do_pop) begin
                count <= count + cnt_t'(1);
            end else if (do_pop && !do_push) begin
                count <= count - cnt_t'(1);
            end
        end
    end

    assign pop_data_o = mem[rd_ptr];
    assign full_o     = (count == cnt_t'(QUEUE_DEPTH));
    assign empty_o    = (count == '0);

endmodule

//--- hw/mips_lite_pkg.sv
package mips_lite_pkg;

    // ========================================================================
    // Data widths
    // ========================================================================

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;

    // Shared by the major opcode field and the SPECIAL function field.
    typedef logic [5:0]  opcode_t;

    // ========================================================================
    // Instruction encodings
    // ========================================================================

    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // Function codes under OP_SPECIAL.
    localparam opcode_t FN_ADDU = 6'h21;
    localparam opcode_t FN_SUBU = 6'h23;
    localparam opcode_t FN_AND  = 6'h24;
    localparam opcode_t FN_OR   = 6'h25;
    localparam opcode_t FN_XOR  = 6'h26;

    // ========================================================================
    // Execute FSM
    // ========================================================================

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_RUN,
        EX_MEM
    } exec_state_t;

endpackage

//--- hw/mips_lite_top.sv
`timescale 1ns/1ps

module mips_lite_top #(
    parameter int                   QUEUE_DEPTH = 4,
    parameter mips_lite_pkg::addr_t RESET_PC    = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // Instruction bus.
    output logic                 ibus_cyc_o,
    output logic                 ibus_stb_o,
    output mips_lite_pkg::addr_t ibus_adr_o,
    input  mips_lite_pkg::word_t ibus_dat_i,
    input  logic                 ibus_ack_i,

    // Data bus.
    output logic                 dbus_cyc_o,
    output logic                 dbus_stb_o,
    output logic                 dbus_we_o,
    output mips_lite_pkg::addr_t dbus_adr_o,
    output mips_lite_pkg::word_t dbus_dat_o,
    input  mips_lite_pkg::word_t dbus_dat_i,
    input  logic                 dbus_ack_i
);

    logic                 push;
    mips_lite_pkg::word_t push_data;
    logic                 full;
    logic                 pop;
    mips_lite_pkg::word_t pop_data;
    logic                 empty;

    fetch_unit #(
        .RESET_PC     (RESET_PC)
    ) u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .queue_full_i (full),
        .push_o       (push),
        .push_data_o  (push_data),
        .ibus_cyc_o   (ibus_cyc_o),
        .ibus_stb_o   (ibus_stb_o),
        .ibus_adr_o   (ibus_adr_o),
        .ibus_dat_i   (ibus_dat_i),
        .ibus_ack_i   (ibus_ack_i)
    );

    inst_queue #(
        .QUEUE_DEPTH  (QUEUE_DEPTH)
    ) u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (push),
        .push_data_i  (push_data),
        .pop_i        (pop),
        .pop_data_o   (pop_data),
        .full_o       (full),
        .empty_o      (empty)
    );

    exec_unit u_exec (
        .clk           (clk),
        .rst_n         (rst_n),
        .queue_empty_i (empty),
        .queue_data_i  (pop_data),
        .pop_o         (pop),
        .dbus_cyc_o    (dbus_cyc_o),
        .dbus_stb_o    (dbus_stb_o),
        .dbus_we_o     (dbus_we_o),
        .dbus_adr_o    (dbus_adr_o),
        .dbus_dat_o    (dbus_dat_o),
        .dbus_dat_i    (dbus_dat_i),
        .dbus_ack_i    (dbus_ack_i)
    );

endmodule

//--- mips_lite_top.f
hw/mips_lite_pkg.sv
hw/fetch_unit.sv
hw/inst_queue.sv
hw/exec_unit.sv
hw/mips_lite_top.sv
tb/mips_lite_asserts.sv
tb/tb_mips_lite.sv

//--- tb/mips_lite_asserts.sv
`timescale 1ns/1ps

module mips_lite_asserts (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       ibus_cyc_i,
    input logic                       ibus_stb_i,
    input mips_lite_pkg::addr_t       ibus_adr_i,
    input logic                       ibus_ack_i,
    input logic                       dbus_cyc_i,
    input logic                       dbus_stb_i,
    input logic                       dbus_we_i,
    input mips_lite_pkg::addr_t       dbus_adr_i,
    input mips_lite_pkg::word_t       dbus_wdat_i,
    input logic                       dbus_ack_i,
    input mips_lite_pkg::exec_state_t exec_state_i
);

    ibus_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        ibus_stb_i |-> ibus_cyc_i)
        else $error("ibus stb high without cyc");

    dbus_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_stb_i |-> dbus_cyc_i)
        else $error("dbus stb high without cyc");

    // Request fields hold until the slave acks.
    ibus_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (ibus_stb_i && !ibus_ack_i) |=> $stable(ibus_adr_i))
        else $error("ibus address changed during a wait state");

    dbus_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (dbus_stb_i && !dbus_ack_i) |=>
            ($stable(dbus_adr_i) && $stable(dbus_we_i) && $stable(dbus_wdat_i)))
        else $error("dbus request changed during a wait state");

    // A data access ends the EX_MEM visit on its ack edge.
    dbus_cyc_ends_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (dbus_cyc_i && dbus_ack_i) |=>
            (!dbus_cyc_i && (exec_state_i == mips_lite_pkg::EX_IDLE)))
        else $error("dbus cycle did not end with execute back in EX_IDLE");

endmodule

//--- tb/tb_mips_lite.sv
`timescale 1ns/1ps

module tb_mips_lite;

    localparam int                   QUEUE_DEPTH     = 4;
    localparam mips_lite_pkg::addr_t RESET_PC        = '0;
    localparam int unsigned          SEED            = 32'he5d368be;
    localparam int                   N_RANDOM        = 200;
    localparam int                   N_PROG          = N_RANDOM + 31;
    localparam int                   RESET_CYCLES    = 4;
    localparam int                   DRAIN_CYCLES    = 40;
    localparam int                   WATCHDOG_CYCLES = RESET_CYCLES + 30 * N_PROG;

    logic                 clk;
    logic                 rst_n;
    logic                 ibus_cyc_o;
    logic                 ibus_stb_o;
    mips_lite_pkg::addr_t ibus_adr_o;
    mips_lite_pkg::word_t ibus_dat_i;
    logic                 ibus_ack_i;
    logic                 dbus_cyc_o;
    logic                 dbus_stb_o;
    logic                 dbus_we_o;
    mips_lite_pkg::addr_t dbus_adr_o;
    mips_lite_pkg::word_t dbus_dat_o;
    mips_lite_pkg::word_t dbus_dat_i;
    logic                 dbus_ack_i;

    mips_lite_pkg::word_t prog_mem [512];
    mips_lite_pkg::word_t data_mem [256];
    mips_lite_pkg::addr_t exp_store_addr [$];
    mips_lite_pkg::word_t exp_store_data [$];
    mips_lite_pkg::addr_t exp_load_addr [$];
    mips_lite_pkg::addr_t exp_fetch_pc = RESET_PC;
    int                   total_stores = 0;
    int                   stores_seen  = 0;
    int                   ibus_wait    = 0;
    int                   dbus_wait    = 0;

    mips_lite_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .RESET_PC    (RESET_PC)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .ibus_cyc_o (ibus_cyc_o),
        .ibus_stb_o (ibus_stb_o),
        .ibus_adr_o (ibus_adr_o),
        .ibus_dat_i (ibus_dat_i),
        .ibus_ack_i (ibus_ack_i),
        .dbus_cyc_o (dbus_cyc_o),
        .dbus_stb_o (dbus_stb_o),
        .dbus_we_o  (dbus_we_o),
        .dbus_adr_o (dbus_adr_o),
        .dbus_dat_o (dbus_dat_o),
        .dbus_dat_i (dbus_dat_i),
        .dbus_ack_i (dbus_ack_i)
    );

    bind mips_lite_top mips_lite_asserts u_asserts (
        .clk          (clk),
        .rst_n        (rst_n),
        .ibus_cyc_i   (ibus_cyc_o),
        .ibus_stb_i   (ibus_stb_o),
        .ibus_adr_i   (ibus_adr_o),
        .ibus_ack_i   (ibus_ack_i),
        .dbus_cyc_i   (dbus_cyc_o),
        .dbus_stb_i   (dbus_stb_o),
        .dbus_we_i    (dbus_we_o),
        .dbus_adr_i   (dbus_adr_o),
        .dbus_wdat_i  (dbus_dat_o),
        .dbus_ack_i   (dbus_ack_i),
        .exec_state_i (u_exec.state)
    );

    always #10 clk = ~clk;

    // ========================================================================
    // Failure reporting and compares
    // ========================================================================

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input mips_lite_pkg::addr_t expected,
                              input mips_lite_pkg::addr_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input mips_lite_pkg::word_t expected,
                              input mips_lite_pkg::word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bus_idle(input string when_txt);
        if (ibus_cyc_o !== 1'b0 || dbus_cyc_o !== 1'b0) begin
            $display("A bus cycle was active %s (ibus_cyc_o=%b, dbus_cyc_o=%b)",
                     when_txt, ibus_cyc_o, dbus_cyc_o);
            abort_run();
        end
    endtask

    // ========================================================================
    // Program generator and ISA model
    // ========================================================================

    function automatic mips_lite_pkg::word_t r_type(input mips_lite_pkg::opcode_t fn,
            input mips_lite_pkg::reg_idx_t rs, input mips_lite_pkg::reg_idx_t rt,
            input mips_lite_pkg::reg_idx_t rd);
        return {mips_lite_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic mips_lite_pkg::word_t i_type(input mips_lite_pkg::opcode_t op,
            input mips_lite_pkg::reg_idx_t rs, input mips_lite_pkg::reg_idx_t rt,
            input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Initial data memory contents, distinct for every word address.
    function automatic mips_lite_pkg::word_t fill_word(input int idx);
        return (mips_lite_pkg::word_t'(idx) * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;
    endfunction

    task automatic build_program();
        int                      kind;
        mips_lite_pkg::reg_idx_t rs;
        mips_lite_pkg::reg_idx_t rt;
        mips_lite_pkg::reg_idx_t rd;
        logic [15:0]             imm;
        logic [15:0]             offs;
        for (int i = 0; i < 512; i++) begin
            prog_mem[i] = '0;
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            kind = $urandom_range(0, 10);
            rs   = mips_lite_pkg::reg_idx_t'($urandom_range(0, 31));
            rt   = mips_lite_pkg::reg_idx_t'($urandom_range(0, 31));
            rd   = mips_lite_pkg::reg_idx_t'($urandom_range(0, 31));
            imm  = 16'($urandom());
            offs = 16'($urandom_range(0, 255) * 4);
            case (kind)
                0: prog_mem[i] = r_type(mips_lite_pkg::FN_ADDU, rs, rt, rd);
                1: prog_mem[i] = r_type(mips_lite_pkg::FN_SUBU, rs, rt, rd);
                2: prog_mem[i] = r_type(mips_lite_pkg::FN_AND, rs, rt, rd);
                3: prog_mem[i] = r_type(mips_lite_pkg::FN_OR, rs, rt, rd);
                4: prog_mem[i] = r_type(mips_lite_pkg::FN_XOR, rs, rt, rd);
                5: prog_mem[i] = i_type(mips_lite_pkg::OP_ADDIU, rs, rt, imm);
                6: prog_mem[i] = i_type(mips_lite_pkg::OP_ORI, rs, rt, imm);
                7: prog_mem[i] = i_type(mips_lite_pkg::OP_LUI, '0, rt, imm);
                8: prog_mem[i] = i_type(mips_lite_pkg::OP_LW, '0, rt, offs);
                9: prog_mem[i] = i_type(mips_lite_pkg::OP_SW, '0, rt, offs);
                // Opcodes 0x30 to 0x3f are outside the supported set.
                default: prog_mem[i] = {6'h30 | 6'($urandom_range(0, 15)), 26'($urandom())};
            endcase
        end
        // Final dump of registers 1 to 31.
        for (int r = 1; r < 32; r++) begin
            prog_mem[N_RANDOM + r - 1] = i_type(mips_lite_pkg::OP_SW, '0,
                                                mips_lite_pkg::reg_idx_t'(r), 16'(r * 4));
        end
    endtask

    task automatic run_model();
        mips_lite_pkg::word_t    m_rf [32];
        mips_lite_pkg::word_t    m_mem [256];
        mips_lite_pkg::word_t    inst;
        mips_lite_pkg::word_t    a;
        mips_lite_pkg::word_t    b;
        mips_lite_pkg::word_t    sext;
        mips_lite_pkg::addr_t    ea;
        mips_lite_pkg::opcode_t  op;
        mips_lite_pkg::opcode_t  fn;
        mips_lite_pkg::reg_idx_t rs;
        mips_lite_pkg::reg_idx_t rt;
        mips_lite_pkg::reg_idx_t rd;
        for (int i = 0; i < 32; i++) begin
            m_rf[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            m_mem[i] = fill_word(i);
        end
        for (int i = 0; i < N_PROG; i++) begin
            inst = prog_mem[i];
            op   = inst[31:26];
            rs   = inst[25:21];
            rt   = inst[20:16];
            rd   = inst[15:11];
            fn   = inst[5:0];
            a    = m_rf[rs];
            b    = m_rf[rt];
            sext = {{16{inst[15]}}, inst[15:0]};
            ea   = a + sext;
            case (op)
                mips_lite_pkg::OP_SPECIAL: begin
                    case (fn)
                        mips_lite_pkg::FN_ADDU: m_rf[rd] = a + b;
                        mips_lite_pkg::FN_SUBU: m_rf[rd] = a - b;
                        mips_lite_pkg::FN_AND:  m_rf[rd] = a & b;
                        mips_lite_pkg::FN_OR:   m_rf[rd] = a | b;
                        mips_lite_pkg::FN_XOR:  m_rf[rd] = a ^ b;
                        default: ;
                    endcase
                end
                mips_lite_pkg::OP_ADDIU: m_rf[rt] = a + sext;
                mips_lite_pkg::OP_ORI:   m_rf[rt] = a | {16'h0000, inst[15:0]};
                mips_lite_pkg::OP_LUI:   m_rf[rt] = {inst[15:0], 16'h0000};
                mips_lite_pkg::OP_LW: begin
                    exp_load_addr.push_back(ea);
                    m_rf[rt] = m_mem[ea[9:2]];
                end
                mips_lite_pkg::OP_SW: begin
                    exp_store_addr.push_back(ea);
                    exp_store_data.push_back(b);
                    m_mem[ea[9:2]] = b;
                end
                default: ;
            endcase
            // Register 0 is hardwired to zero.
            m_rf[0] = '0;
        end
    endtask

    // ========================================================================
    // Bus slaves
    // ========================================================================

    always begin
        @(posedge clk);
        #1;
        ibus_ack_i = 1'b0;
        if (ibus_cyc_o && ibus_stb_o) begin
            if (ibus_wait != 0) begin
                ibus_wait--;
            end else begin
                check_addr("ibus_adr_o", exp_fetch_pc, ibus_adr_o);
                exp_fetch_pc = exp_fetch_pc + 32'd4;
                if (ibus_adr_o < mips_lite_pkg::addr_t'(N_PROG * 4)) begin
                    ibus_dat_i = prog_mem[ibus_adr_o[10:2]];
                end else begin
                    ibus_dat_i = '0;
                end
                ibus_ack_i = 1'b1;
                ibus_wait  = $urandom_range(0, 3);
            end
        end
    end

    task automatic serve_data_access();
        logic [7:0] widx;
        widx = dbus_adr_o[9:2];
        if (dbus_we_o && exp_store_addr.size() == 0) begin
            $display("Unexpected dbus write to %h after all expected stores", dbus_adr_o);
            abort_run();
        end else if (!dbus_we_o && exp_load_addr.size() == 0) begin
            $display("Unexpected dbus read from %h with no LW left", dbus_adr_o);
            abort_run();
        end else if (dbus_we_o) begin
            check_addr("dbus_adr_o", exp_store_addr.pop_front(), dbus_adr_o);
            check_word("dbus_dat_o", exp_store_data.pop_front(), dbus_dat_o);
            data_mem[widx] = dbus_dat_o;
            stores_seen++;
        end else begin
            check_addr("dbus_adr_o", exp_load_addr.pop_front(), dbus_adr_o);
            dbus_dat_i = data_mem[widx];
        end
    endtask

    always begin
        @(posedge clk);
        #1;
        dbus_ack_i = 1'b0;
        if (dbus_cyc_o && dbus_stb_o) begin
            if (dbus_wait != 0) begin
                dbus_wait--;
            end else begin
                serve_data_access();
                dbus_ack_i = 1'b1;
                dbus_wait  = $urandom_range(0, 3);
            end
        end
    end

    // ========================================================================
    // Main sequence and watchdog
    // ========================================================================

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with %0d of %0d stores seen",
                 WATCHDOG_CYCLES, stores_seen, total_stores);
        abort_run();
    end

    initial begin : main_seq
        clk        = 1'b0;
        rst_n      = 1'b0;
        ibus_dat_i = '0;
        ibus_ack_i = 1'b0;
        dbus_dat_i = '0;
        dbus_ack_i = 1'b0;
        void'($urandom(SEED));
        build_program();
        run_model();
        total_stores = exp_store_addr.size();
        for (int i = 0; i < 256; i++) begin
            data_mem[i] = fill_word(i);
        end
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_bus_idle("during reset");
        end
        rst_n = 1'b1;
        check_bus_idle("right after reset");
        wait (stores_seen == total_stores);
        // Extra cycles catch any write beyond the expected list.
        repeat (DRAIN_CYCLES) @(posedge clk);
        if (exp_load_addr.size() != 0) begin
            $display("%0d expected dbus reads never happened", exp_load_addr.size());
            abort_run();
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule
